// File: flist.f
+incdir+include
hdl/vga_snake_pkg.sv
hdl/vga_timing.sv
hdl/host_regs.sv
hdl/tile_map_arbiter.sv
hdl/tile_map.sv
hdl/pixel_renderer.sv
hdl/vga_snake_top.sv
tests/tb_vga_snake.sv

// File: hdl/host_regs.sv
`timescale 1ns/10ps
`include "vga_snake_macros.svh"

module host_regs
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic chipselect,
  input logic write,
  input bus_addr_t address,
  input bus_data_t writedata,
  output logic wr_req,
  output cell_addr_t wr_addr,
  output tile_code_t wr_tile
);

  map_coord_t col_q;
  map_coord_t row_q;
  logic bus_wr;

  assign bus_wr = chipselect && write;

  // --------------------
  // cell position registers
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col_q <= '0;
      row_q <= '0;
    end else if (bus_wr) begin
      // only the low nibble counts
      if (address == bus_addr_t'(`REG_COL)) begin
        col_q <= writedata[3:0];
      end
      if (address == bus_addr_t'(`REG_ROW)) begin
        row_q <= writedata[3:0];
      end
    end
  end

  // tile write commits the cell, one-cycle pulse
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_req <= 1'b0;
    end else begin
      wr_req <= bus_wr && (address == bus_addr_t'(`REG_TILE));
    end
  end

  // tile code payload
  always_ff @(posedge clk) begin
    if (bus_wr && (address == bus_addr_t'(`REG_TILE))) begin
      wr_tile <= writedata[3:0];
    end
  end

  // row in the upper half
  assign wr_addr = {row_q, col_q};

endmodule

// File: hdl/pixel_renderer.sv
`timescale 1ns/10ps
`include "vga_snake_macros.svh"

module pixel_renderer
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic reset,
  input hcount_t hcount,
  input vcount_t vcount,
  input logic hsync,
  input logic vsync,
  input logic blank_n,
  input tile_code_t rd_tile,
  output logic rd_req,
  output cell_addr_t rd_addr,
  output color8_t vga_r,
  output color8_t vga_g,
  output color8_t vga_b,
  output logic vga_hs,
  output logic vga_vs,
  output logic vga_blank_n,
  output logic vga_clk
);

  // stages ahead of the output register
  localparam int unsigned PIPE_DEPTH = `RENDER_LATENCY - 1;
  // {in_map, hs, vs, blank_n, pixel clk}
  localparam logic [4:0] TIM_IDLE = 5'b01100;

  logic in_map;
  logic [4:0] tim_word;
  logic [4:0] tim_pipe [PIPE_DEPTH];
  logic [4:0] tim_last;
  rgb565_t tile_rgb;

  // --------------------
  // tile fetch
  // --------------------
  // 32 counter cycles by 16 lines per cell
  assign in_map = (hcount[10:5] < 6'(`MAP_DIM)) && (vcount[9:4] < 6'(`MAP_DIM));
  // one fetch at the left edge of each cell
  assign rd_req = in_map && (hcount[4:0] == 5'd0);
  assign rd_addr = {vcount[7:4], hcount[8:5]};

  // --------------------
  // timing delay line
  // --------------------
  assign tim_word = {in_map, hsync, vsync, blank_n, hcount[0]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < PIPE_DEPTH; i++) begin
        tim_pipe[i] <= TIM_IDLE;
      end
    end else begin
      tim_pipe[0] <= tim_word;
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        tim_pipe[i] <= tim_pipe[i-1];
      end
    end
  end

  // lines up with rd_tile from the map
  assign tim_last = tim_pipe[PIPE_DEPTH-1];
  assign tile_rgb = palette_lookup(rd_tile);

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_blank_n <= 1'b0;
      vga_clk <= 1'b0;
    end else begin
      vga_hs <= tim_last[3];
      vga_vs <= tim_last[2];
      vga_blank_n <= tim_last[1];
      vga_clk <= tim_last[0];
      // black off the map and in blanking
      if (tim_last[4] && tim_last[1]) begin
        vga_r <= {tile_rgb[15:11], 3'b000};
        vga_g <= {tile_rgb[10:5], 2'b00};
        vga_b <= {tile_rgb[4:0], 3'b000};
      end else begin
        vga_r <= '0;
        vga_g <= '0;
        vga_b <= '0;
      end
    end
  end

endmodule

// File: hdl/tile_map.sv
`timescale 1ns/10ps
`include "vga_snake_macros.svh"

module tile_map
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic mem_we,
  input cell_addr_t mem_addr,
  input tile_code_t mem_wdata,
  output tile_code_t rd_tile
);

  localparam int unsigned DEPTH = `MAP_DIM * `MAP_DIM;

  tile_code_t mem [DEPTH];

  // map starts out empty
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // single port, read held across write cycles
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end else begin
      rd_tile <= mem[mem_addr];
    end
  end

endmodule

// File: hdl/tile_map_arbiter.sv
`timescale 1ns/10ps

module tile_map_arbiter
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic wr_req,
  input logic rd_req,
  input cell_addr_t wr_addr,
  input cell_addr_t rd_addr,
  input tile_code_t wr_tile,
  output logic mem_we,
  output cell_addr_t mem_addr,
  output tile_code_t mem_wdata
);

  logic pending;
  cell_addr_t pend_addr;
  tile_code_t pend_tile;

  // --------------------
  // pending host write
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (wr_req) begin
      pending <= 1'b1;
    end else if (mem_we) begin
      // drained into the map
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req) begin
      pend_addr <= wr_addr;
      pend_tile <= wr_tile;
    end
  end

  // --------------------
  // port steering
  // --------------------
  // renderer always wins, write slips into a free cycle
  assign mem_we = pending && !rd_req;
  // idle cycles re-read the renderer's current cell
  assign mem_addr = mem_we ? pend_addr : rd_addr;
  assign mem_wdata = pend_tile;

  // host commits must be spaced past the drain
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    wr_req |-> !pending);

  // fetches are a tile apart, so a write waits at most one cycle
  a_rd_spacing: assert property (@(posedge clk) disable iff (reset)
    rd_req |=> !rd_req);

endmodule

// File: hdl/vga_snake_pkg.sv
package vga_snake_pkg;

  // --------------------
  // vector types
  // --------------------
  // bit 0 is the pixel phase
  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;
  typedef logic [3:0] map_coord_t;
  // {row, col}
  typedef logic [7:0] cell_addr_t;
  typedef logic [3:0] tile_code_t;
  // r5 g6 b5
  typedef logic [15:0] rgb565_t;
  typedef logic [7:0] color8_t;
  typedef logic [7:0] bus_data_t;
  typedef logic [2:0] bus_addr_t;

  // --------------------
  // palette
  // --------------------
  localparam rgb565_t pal_empty = 16'h0300;
  localparam rgb565_t pal_apple = 16'hf800;
  localparam rgb565_t pal_head = 16'hffe0;
  localparam rgb565_t pal_body = 16'h07e0;
  localparam rgb565_t pal_wall = 16'h8410;

  // codes 4 and up are all wall
  function automatic rgb565_t palette_lookup(input tile_code_t code);
    case (code)
      4'd0: return pal_empty;
      4'd1: return pal_apple;
      4'd2: return pal_head;
      4'd3: return pal_body;
      default: return pal_wall;
    endcase
  endfunction

endpackage

// File: hdl/vga_snake_top.sv
`timescale 1ns/10ps

module vga_snake_top
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic chipselect,
  input logic write,
  input bus_addr_t address,
  input bus_data_t writedata,
  output color8_t VGA_R,
  output color8_t VGA_G,
  output color8_t VGA_B,
  output logic VGA_CLK,
  output logic VGA_HS,
  output logic VGA_VS,
  output logic VGA_BLANK_n
);

  // --------------------
  // timing
  // --------------------
  hcount_t hcount;
  vcount_t vcount;
  logic hsync;
  logic vsync;
  logic blank_n;

  // host side
  logic wr_req;
  cell_addr_t wr_addr;
  tile_code_t wr_tile;

  // renderer side
  logic rd_req;
  cell_addr_t rd_addr;
  tile_code_t rd_tile;

  // shared map port
  logic mem_we;
  cell_addr_t mem_addr;
  tile_code_t mem_wdata;

  vga_timing u_timing (
    .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync), .blank_n(blank_n)
  );

  host_regs u_regs (
    .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
    .address(address), .writedata(writedata),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_tile(wr_tile)
  );

  tile_map_arbiter u_arb (
    .clk(clk), .reset(reset), .wr_req(wr_req), .rd_req(rd_req),
    .wr_addr(wr_addr), .rd_addr(rd_addr), .wr_tile(wr_tile),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  tile_map u_map (
    .clk(clk), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .rd_tile(rd_tile)
  );

  pixel_renderer u_render (
    .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync), .blank_n(blank_n), .rd_tile(rd_tile),
    .rd_req(rd_req), .rd_addr(rd_addr),
    .vga_r(VGA_R), .vga_g(VGA_G), .vga_b(VGA_B),
    .vga_hs(VGA_HS), .vga_vs(VGA_VS), .vga_blank_n(VGA_BLANK_n), .vga_clk(VGA_CLK)
  );

endmodule

// File: hdl/vga_timing.sv
`timescale 1ns/10ps
`include "vga_snake_macros.svh"

module vga_timing
  import vga_snake_pkg::*;
(
  input logic clk,
  input logic reset,
  output hcount_t hcount,
  output vcount_t vcount,
  output logic hsync,
  output logic vsync,
  output logic blank_n
);

  logic end_of_line;
  logic end_of_frame;

  assign end_of_line = (hcount == hcount_t'(`H_TOTAL - 1));
  assign end_of_frame = (vcount == vcount_t'(`V_TOTAL - 1));

  // --------------------
  // counters
  // --------------------
  // two counter cycles per pixel
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // line counter steps at the end of each line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // --------------------
  // sync and blanking
  // --------------------
  // hsync low 1312..1503, after the front porch
  assign hsync = !((hcount >= hcount_t'(`H_ACTIVE + `H_FRONT)) &&
                   (hcount < hcount_t'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
  // vsync low on lines 490 and 491
  assign vsync = !((vcount >= vcount_t'(`V_ACTIVE + `V_FRONT)) &&
                   (vcount < vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
  assign blank_n = (hcount < hcount_t'(`H_ACTIVE)) && (vcount < vcount_t'(`V_ACTIVE));

  // wrap points hold over time
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    (hcount < hcount_t'(`H_TOTAL)) && (vcount < vcount_t'(`V_TOTAL)));

endmodule

// File: include/vga_snake_macros.svh
`ifndef VGA_SNAKE_MACROS_SVH
`define VGA_SNAKE_MACROS_SVH

// --------------------
// horizontal timing, in 50 MHz counter cycles
// --------------------
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96
`define H_TOTAL 1600

// --------------------
// vertical timing, in lines
// --------------------
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// map cells per side
`define MAP_DIM 16

// host register addresses
`define REG_COL 0
`define REG_ROW 1
`define REG_TILE 2

// counters to rgb pins
`define RENDER_LATENCY 2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tile display testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f flist.f --top-module tb_vga_snake -o sim_vga_snake

./obj_dir/sim_vga_snake | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: tests/tb_vga_snake.sv
`timescale 1ns/10ps
`include "vga_snake_macros.svh"

module tb_vga_snake
  import vga_snake_pkg::*;
();

  localparam int N_ROWS = 8;
  localparam int TIMEOUT_CYCLES = 4 * `H_TOTAL * `V_TOTAL + 1000;

  logic clk;
  logic reset;
  logic chipselect;
  logic write;
  bus_addr_t address;
  bus_data_t writedata;
  color8_t VGA_R;
  color8_t VGA_G;
  color8_t VGA_B;
  logic VGA_CLK;
  logic VGA_HS;
  logic VGA_VS;
  logic VGA_BLANK_n;

  // stimulus table, one map cell per row
  map_coord_t tbl_col [N_ROWS] = '{4'd0, 4'd1, 4'd2, 4'd15, 4'd15, 4'd0, 4'd7, 4'd8};
  map_coord_t tbl_row [N_ROWS] = '{4'd0, 4'd0, 4'd0, 4'd15, 4'd0, 4'd15, 4'd8, 4'd7};
  tile_code_t tbl_code [N_ROWS] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd9, 4'd15, 4'd3, 4'd1};
  rgb565_t tbl_rgb [N_ROWS] = '{pal_apple, pal_head, pal_body, pal_wall,
                                pal_wall, pal_wall, pal_body, pal_apple};

  // host view of the map and the copy the current frame shows, [row][col]
  rgb565_t host_map [`MAP_DIM][`MAP_DIM];
  rgb565_t disp_map [`MAP_DIM][`MAP_DIM];

  // counter model and its two-stage delay line
  hcount_t mh;
  vcount_t mv;
  int frame_cnt;
  int cycle_cnt = 0;
  logic check_en = 1'b0;
  rgb565_t p_rgb [2];
  logic p_hs [2];
  logic p_vs [2];
  logic p_bn [2];
  logic p_clk [2];
  hcount_t p_h [2];
  vcount_t p_v [2];
  integer seed;

  vga_snake_top u_dut (
    .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
    .address(address), .writedata(writedata),
    .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B), .VGA_CLK(VGA_CLK),
    .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .VGA_BLANK_n(VGA_BLANK_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic color8_t red_of(input rgb565_t c);
    return {c[15:11], 3'b000};
  endfunction

  function automatic color8_t green_of(input rgb565_t c);
    return {c[10:5], 2'b00};
  endfunction

  function automatic color8_t blue_of(input rgb565_t c);
    return {c[4:0], 3'b000};
  endfunction

  // black off the map and in blanking, 32 cycles by 16 lines per cell
  function automatic rgb565_t pixel_color(input hcount_t h, input vcount_t v);
    logic active;
    logic on_map;
    active = (h < hcount_t'(`H_ACTIVE)) && (v < vcount_t'(`V_ACTIVE));
    on_map = (h < hcount_t'(`MAP_DIM * 32)) && (v < vcount_t'(`MAP_DIM * 16));
    if (active && on_map) begin
      return disp_map[map_coord_t'(v / 16)][map_coord_t'(h / 32)];
    end else begin
      return '0;
    end
  endfunction

  function automatic string phase_name();
    case (frame_cnt)
      0: return "empty map";
      1: return "table writes";
      2: return "active video rewrite";
      default: return "blanking rewrite";
    endcase
  endfunction

  // mirrors the DUT counters, outputs trail by two cycles
  always @(posedge clk) begin
    check_en <= 1'b1;
    if (reset) begin
      mh <= '0;
      mv <= '0;
      frame_cnt <= 0;
      for (int i = 0; i < 2; i++) begin
        p_rgb[i] <= '0;
        p_hs[i] <= 1'b1;
        p_vs[i] <= 1'b1;
        p_bn[i] <= 1'b0;
        p_clk[i] <= 1'b0;
        p_h[i] <= '0;
        p_v[i] <= '0;
      end
    end else begin
      // new frame picks up all host writes so far
      if (mh == '0 && mv == '0) begin
        disp_map = host_map;
      end
      p_rgb[0] <= pixel_color(mh, mv);
      p_hs[0] <= !((mh >= hcount_t'(`H_ACTIVE + `H_FRONT)) &&
                   (mh < hcount_t'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
      p_vs[0] <= !((mv >= vcount_t'(`V_ACTIVE + `V_FRONT)) &&
                   (mv < vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
      p_bn[0] <= (mh < hcount_t'(`H_ACTIVE)) && (mv < vcount_t'(`V_ACTIVE));
      p_clk[0] <= mh[0];
      p_h[0] <= mh;
      p_v[0] <= mv;
      p_rgb[1] <= p_rgb[0];
      p_hs[1] <= p_hs[0];
      p_vs[1] <= p_vs[0];
      p_bn[1] <= p_bn[0];
      p_clk[1] <= p_clk[0];
      p_h[1] <= p_h[0];
      p_v[1] <= p_v[0];
      if (mh == hcount_t'(`H_TOTAL - 1)) begin
        mh <= '0;
        if (mv == vcount_t'(`V_TOTAL - 1)) begin
          mv <= '0;
          frame_cnt <= frame_cnt + 1;
        end else begin
          mv <= mv + 10'd1;
        end
      end else begin
        mh <= mh + 11'd1;
      end
    end
  end

  // --------------------
  // checks
  // --------------------
  task automatic check_color(input string what, input color8_t expected, input color8_t actual);
    if (actual !== expected) begin
      $display("error %s %s at h=%0d v=%0d expected %02h actual %02h",
               phase_name(), what, p_h[1], p_v[1], expected, actual);
      $display("Finished with errors");
      $fatal(1, "colour mismatch");
    end
  endtask

  task automatic check_sync(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s %s at h=%0d v=%0d expected %0b actual %0b",
               phase_name(), what, p_h[1], p_v[1], expected, actual);
      $display("Finished with errors");
      $fatal(1, "sync mismatch");
    end
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (check_en) begin
      check_color("vga_r", red_of(p_rgb[1]), VGA_R);
      check_color("vga_g", green_of(p_rgb[1]), VGA_G);
      check_color("vga_b", blue_of(p_rgb[1]), VGA_B);
      check_sync("vga_hs", p_hs[1], VGA_HS);
      check_sync("vga_vs", p_vs[1], VGA_VS);
      check_sync("vga_blank_n", p_bn[1], VGA_BLANK_n);
      check_sync("vga_clk", p_clk[1], VGA_CLK);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    chipselect = 1'b1;
    write = 1'b1;
    address = addr;
    writedata = data;
    @(negedge clk);
    chipselect = 1'b0;
    write = 1'b0;
  endtask

  // upper nibbles carry junk, only the low 4 bits count
  task automatic commit_cell(input map_coord_t col, input map_coord_t row,
                             input tile_code_t code, input rgb565_t rgb);
    bus_write(bus_addr_t'(`REG_COL), {4'h5, col});
    bus_write(bus_addr_t'(`REG_ROW), {4'ha, row});
    bus_write(bus_addr_t'(`REG_TILE), {4'hc, code});
    host_map[row][col] = rgb;
    // gap lets the pending write drain
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_for(input int f, input int line, input int pix);
    while (!(frame_cnt == f && int'(mv) == line && int'(mh) == pix)) begin
      @(negedge clk);
    end
  endtask

  initial begin
    int pick;
    int line_sel;
    int pix_sel;
    reset = 1'b1;
    chipselect = 1'b0;
    write = 1'b0;
    address = '0;
    writedata = '0;
    seed = 88287;
    for (int r = 0; r < `MAP_DIM; r++) begin
      for (int c = 0; c < `MAP_DIM; c++) begin
        host_map[r][c] = pal_empty;
        disp_map[r][c] = pal_empty;
      end
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // frame 0 shows the empty map, load during its vertical blanking
    wait_for(0, 482, 0);
    for (int i = 0; i < 4; i++) begin
      pick = $random(seed) & 7;
      commit_cell(map_coord_t'($random(seed)), map_coord_t'($random(seed)),
                  tbl_code[pick], tbl_rgb[pick]);
    end
    for (int i = 0; i < N_ROWS; i++) begin
      commit_cell(tbl_col[i], tbl_row[i], tbl_code[i], tbl_rgb[i]);
    end

    // frame 1, random active time below the map rows
    line_sel = 256 + ($random(seed) & 127);
    pix_sel = $random(seed) & 1023;
    wait_for(1, line_sel, pix_sel);
    commit_cell(4'd0, 4'd0, 4'd3, pal_body);

    // frame 2 blanking, rewrite two more cells
    wait_for(2, 485, 0);
    commit_cell(4'd1, 4'd0, 4'd0, pal_empty);
    commit_cell(4'd15, 4'd15, 4'd2, pal_head);

    // all map rows of frame 3, down to the bottom row
    wait_for(3, 256, 0);
    $display("Finished with no errors");
    $finish;
  end

endmodule
